// ==== files.f ====
+incdir+verilog
verilog/apb_bus_pkg.sv
verilog/regfile_map_pkg.sv
verilog/reg_values_if.sv
verilog/regfile_decode.sv
verilog/regfile_storage.sv
verilog/regfile_readback.sv
verilog/top_regfile.sv
tests/regfile_assertions.sv
tests/tb_top_regfile.sv

// ==== tests/regfile_assertions.sv ====
// ------------------------------------------------
// Protocol checks for the config register file.
// Bound into top_regfile; counts assertion fails.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module regfile_assertions (
    input logic                   clk,
    input logic                   reset,
    input logic                   req_psel,
    input logic                   req_penable,
    input logic                   req_pwrite,
    input apb_bus_pkg::bus_data_t req_prdata,
    input logic                   rf_capture_start,
    input logic                   rf_capture_again,
    input logic                   rf_mdio_read_pulse
);

    int failures = 0;

    // Strobes last exactly one cycle
    a_start_pulse: assert property (@(posedge clk) disable iff (reset)
        rf_capture_start |=> !rf_capture_start)
        else begin failures++; $error("capture start strobe high for two cycles"); end
    a_again_pulse: assert property (@(posedge clk) disable iff (reset)
        rf_capture_again |=> !rf_capture_again)
        else begin failures++; $error("capture again strobe high for two cycles"); end
    a_read_pulse: assert property (@(posedge clk) disable iff (reset)
        rf_mdio_read_pulse |=> !rf_mdio_read_pulse)
        else begin failures++; $error("MDIO read pulse high for two cycles"); end

    a_prdata_idle: assert property (@(posedge clk)
        !(req_psel && req_penable && !req_pwrite) |-> req_prdata == '0)
        else begin failures++; $error("read data not zero outside a read access"); end

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> !rf_capture_start && !rf_capture_again && !rf_mdio_read_pulse)
        else begin failures++; $error("strobe high during reset"); end

endmodule

bind top_regfile regfile_assertions u_assertions (.*);

`default_nettype wire

// ==== tests/tb_top_regfile.sv ====
// ------------------------------------------------
// Testbench for the config register file. Random
// APB accesses and device captures are checked
// against a register model; a watchdog bounds the run.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "regfile_defs.svh"

module tb_top_regfile;

    localparam int  NUM_TXNS    = 400;
    localparam time WATCHDOG_NS = (NUM_TXNS * 3 * 20 + 8 * 20) * 3 / 2;

    logic clk, reset, req_pwrite, req_psel, req_penable, rf_mdio_pkt_data_we;
    apb_bus_pkg::bus_addr_t      req_paddr;
    apb_bus_pkg::bus_data_t      req_pwdata, req_prdata;
    regfile_map_pkg::phy_addr_t  legal_phy_addr, legal_phy_addr_mask, broadcast_addr;
    logic broadcast_mode, non_zero_detect, opendrain_mode, watchdog_enable, sync_select;
    logic rf_self_test_mode, rf_capture_mode, rf_capture_start, rf_capture_again;
    logic rf_96path_en, rf_mdio_read_pulse;
    regfile_map_pkg::pkt_len_t   rf_pkt_data_length;
    regfile_map_pkg::idle_len_t  rf_pkt_idle_length;
    regfile_map_pkg::mdio_sel_t  rf_mdio_data_sel;
    regfile_map_pkg::mdio_addr_t rf_mdio_memory_addr;
    regfile_map_pkg::mdio_pkt_t  rf_mdio_pkt_data;

    // Readable word of each register, plus expected strobes
    apb_bus_pkg::bus_data_t model [0:7];
    logic exp_start, exp_again, exp_pulse;
    logic [31:0] rng_state = 32'd39939;
    int errors = 0;

    top_regfile dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all transactions completed");
        $display("test failed");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Bits a bus write may change, per address
    function automatic apb_bus_pkg::bus_data_t writable_bits(input int addr);
        case (addr)
            0: return 16'h7fff;
            1: return 16'h001f;
            2: return 16'h0079;
            3: return 16'hffff;
            4: return 16'h7fff;
            5: return 16'h007f;
            default: return 16'h0000;
        endcase
    endfunction

    task automatic check_read(input apb_bus_pkg::bus_data_t got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_phy_addr(input regfile_map_pkg::phy_addr_t got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_strobe(input logic got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_pkt_data(input regfile_map_pkg::mdio_pkt_t got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_idle_len(input regfile_map_pkg::idle_len_t got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mdio_addr(input regfile_map_pkg::mdio_addr_t got, exp,
                                   input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mdio_sel(input regfile_map_pkg::mdio_sel_t got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pkt_len(input regfile_map_pkg::pkt_len_t got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_phy_addr(legal_phy_addr, model[0][`LEGAL_ADDR_MSB:`LEGAL_ADDR_LSB], "legal addr");
        check_phy_addr(legal_phy_addr_mask, model[0][`ADDR_MASK_MSB:`ADDR_MASK_LSB], "addr mask");
        check_phy_addr(broadcast_addr, model[0][`BCAST_ADDR_MSB:`BCAST_ADDR_LSB], "bcast addr");
        check_strobe(broadcast_mode, model[1][`MODE_BCAST_BIT], "broadcast_mode");
        check_strobe(non_zero_detect, model[1][`MODE_NZD_BIT], "non_zero_detect");
        check_strobe(opendrain_mode, model[1][`MODE_OD_BIT], "opendrain_mode");
        check_strobe(watchdog_enable, model[1][`MODE_WDOG_BIT], "watchdog_enable");
        check_strobe(sync_select, model[1][`MODE_SYNC_BIT], "sync_select");
        check_strobe(rf_self_test_mode, model[2][`PKT_SELF_TEST_BIT], "self_test_mode");
        check_pkt_len(rf_pkt_data_length, model[2][`PKT_LEN_MSB:`PKT_LEN_LSB], "data length");
        check_strobe(rf_capture_mode, model[2][`PKT_CAP_MODE_BIT], "capture_mode");
        check_strobe(rf_96path_en, model[2][`PKT_PATH96_BIT], "96path_en");
        check_idle_len(rf_pkt_idle_length, model[3], "idle length");
        check_mdio_addr(rf_mdio_memory_addr, model[4][14:0], "mdio memory addr");
        check_mdio_sel(rf_mdio_data_sel, model[5][6:0], "mdio data sel");
        check_pkt_data(dut.vals.mdio_pkt_data, model[6][8:0], "mdio packet data");
        check_strobe(rf_capture_start, exp_start, "capture_start strobe");
        check_strobe(rf_capture_again, exp_again, "capture_again strobe");
        check_strobe(rf_mdio_read_pulse, exp_pulse, "mdio_read_pulse strobe");
    endtask

    // Setup, access and one idle cycle; a capture may ride in the idle cycle
    task automatic run_transaction(input int addr, input logic wr,
                                   input apb_bus_pkg::bus_data_t data,
                                   input logic cap, input regfile_map_pkg::mdio_pkt_t cap_data);
        @(posedge clk);
        req_psel            <= 1'b1;
        req_penable         <= 1'b0;
        req_paddr           <= apb_bus_pkg::bus_addr_t'(addr);
        req_pwrite          <= wr;
        req_pwdata          <= data;
        rf_mdio_pkt_data_we <= 1'b0;
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        req_penable <= 1'b1;
        @(negedge clk);
        if (!wr) begin
            check_read(req_prdata, (addr < 8) ? model[addr] : 16'h0000,
                       $sformatf("addr %0d", addr));
        end
        @(posedge clk);
        req_psel            <= 1'b0;
        req_penable         <= 1'b0;
        rf_mdio_pkt_data_we <= cap;
        rf_mdio_pkt_data    <= cap_data;
        if (wr && addr < 8) begin
            model[addr] = (model[addr] & ~writable_bits(addr)) | (data & writable_bits(addr));
        end
        exp_start = wr && addr == 2 && data[`PKT_CAP_START_BIT];
        exp_again = wr && addr == 2 && data[`PKT_CAP_AGAIN_BIT];
        exp_pulse = wr && addr == 7 && data[`MDIO_READ_BIT];
        @(negedge clk);
        check_outputs();
        if (cap) begin
            model[6] = {7'b0, cap_data};
        end
        exp_start = 1'b0;
        exp_again = 1'b0;
        exp_pulse = 1'b0;
    endtask

    initial begin
        logic [31:0] r1, r2;
        reset               <= 1'b1;
        req_paddr           <= '0;
        req_pwrite          <= 1'b0;
        req_psel            <= 1'b0;
        req_penable         <= 1'b0;
        req_pwdata          <= '0;
        rf_mdio_pkt_data    <= '0;
        rf_mdio_pkt_data_we <= 1'b0;
        model = '{16'h7fff, 16'h0014, 16'h0001, 16'h7fff, 16'h0, 16'h0, 16'h0, 16'h0};
        exp_start = 1'b0;
        exp_again = 1'b0;
        exp_pulse = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_outputs();
        for (int a = 0; a < 8; a++) begin
            run_transaction(a, 1'b0, 16'h0, 1'b0, '0);
        end
        for (int n = 0; n < NUM_TXNS; n++) begin
            r1 = next_random();
            r2 = next_random();
            run_transaction(r1 % 10, r1[16], r2[15:0], r1[21:20] == 2'b00, r2[24:16]);
        end
        @(posedge clk);
        rf_mdio_pkt_data_we <= 1'b0;
        @(negedge clk);
        check_outputs();
        errors += dut.u_assertions.failures;
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/apb_bus_pkg.sv ====
// ------------------------------------------------
// Bus side types for the APB slave port.
// Address, data word and the classified access.
// ------------------------------------------------
`default_nettype none

`include "regfile_defs.svh"

package apb_bus_pkg;

    typedef logic [`REGFILE_ADDR_W-1:0] bus_addr_t;
    typedef logic [`REGFILE_DATA_W-1:0] bus_data_t;

    // Access as seen in the access phase
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } apb_op_e;

endpackage

`default_nettype wire

// ==== verilog/reg_values_if.sv ====
// ------------------------------------------------
// Current register values, driven by storage and
// read by readback and the top level outputs.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface reg_values_if;

    regfile_map_pkg::phy_addr_t  legal_phy_addr;
    regfile_map_pkg::phy_addr_t  legal_phy_addr_mask;
    regfile_map_pkg::phy_addr_t  broadcast_addr;
    logic                        broadcast_mode;
    logic                        non_zero_detect;
    logic                        opendrain_mode;
    logic                        watchdog_enable;
    logic                        sync_select;
    logic                        self_test_mode;
    regfile_map_pkg::pkt_len_t   pkt_data_length;
    logic                        capture_mode;
    logic                        capture_start;
    logic                        capture_again;
    logic                        path96_en;
    regfile_map_pkg::idle_len_t  pkt_idle_length;
    regfile_map_pkg::mdio_addr_t mdio_memory_addr;
    regfile_map_pkg::mdio_sel_t  mdio_data_sel;
    regfile_map_pkg::mdio_pkt_t  mdio_pkt_data;
    logic                        mdio_read_pulse;

    modport storage (
        output legal_phy_addr, legal_phy_addr_mask, broadcast_addr,
        output broadcast_mode, non_zero_detect, opendrain_mode, watchdog_enable, sync_select,
        output self_test_mode, pkt_data_length, capture_mode, capture_start, capture_again,
        output path96_en, pkt_idle_length, mdio_memory_addr, mdio_data_sel, mdio_pkt_data,
        output mdio_read_pulse
    );

    modport readback (
        input legal_phy_addr, legal_phy_addr_mask, broadcast_addr,
        input broadcast_mode, non_zero_detect, opendrain_mode, watchdog_enable, sync_select,
        input self_test_mode, pkt_data_length, capture_mode, capture_start, capture_again,
        input path96_en, pkt_idle_length, mdio_memory_addr, mdio_data_sel, mdio_pkt_data,
        input mdio_read_pulse
    );

    // Device side view of every field
    modport observer (
        input legal_phy_addr, legal_phy_addr_mask, broadcast_addr,
        input broadcast_mode, non_zero_detect, opendrain_mode, watchdog_enable, sync_select,
        input self_test_mode, pkt_data_length, capture_mode, capture_start, capture_again,
        input path96_en, pkt_idle_length, mdio_memory_addr, mdio_data_sel, mdio_pkt_data,
        input mdio_read_pulse
    );

endinterface

`default_nettype wire

// ==== verilog/regfile_decode.sv ====
// ------------------------------------------------
// APB access decode. Classifies the bus phase into
// an operation and maps the address to a register.
// Purely combinational.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "regfile_defs.svh"

module regfile_decode (
    input  apb_bus_pkg::bus_addr_t       req_paddr,
    input  logic                         req_psel,
    input  logic                         req_penable,
    input  logic                         req_pwrite,
    output apb_bus_pkg::apb_op_e         op,
    output regfile_map_pkg::reg_index_e  index
);

    // Zero wait states, so the access phase is the whole transfer
    always_comb begin
        if (req_psel && req_penable) begin
            op = req_pwrite ? apb_bus_pkg::OP_WRITE : apb_bus_pkg::OP_READ;
        end else begin
            op = apb_bus_pkg::OP_IDLE;
        end
    end

    // Full address compare, no aliasing
    always_comb begin
        case (req_paddr)
            `ADDR_PHY_ADDR:  index = regfile_map_pkg::REG_PHY_ADDR;
            `ADDR_PHY_MODE:  index = regfile_map_pkg::REG_PHY_MODE;
            `ADDR_PKT_CTRL:  index = regfile_map_pkg::REG_PKT_CTRL;
            `ADDR_IDLE_LEN:  index = regfile_map_pkg::REG_IDLE_LEN;
            `ADDR_MDIO_ADDR: index = regfile_map_pkg::REG_MDIO_ADDR;
            `ADDR_MDIO_SEL:  index = regfile_map_pkg::REG_MDIO_SEL;
            `ADDR_MDIO_DATA: index = regfile_map_pkg::REG_MDIO_DATA;
            `ADDR_MDIO_CMD:  index = regfile_map_pkg::REG_MDIO_CMD;
            default:         index = regfile_map_pkg::REG_NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/regfile_defs.svh ====
// ------------------------------------------------
// Register map constants for the PHY config block.
// Widths, addresses, field positions and reset
// values; include wherever these are needed.
// ------------------------------------------------
`ifndef REGFILE_DEFS_SVH
`define REGFILE_DEFS_SVH

// Bus and field widths
`define REGFILE_ADDR_W      21
`define REGFILE_DATA_W      16
`define PHY_ADDR_W          5
`define PKT_LEN_SEL_W       2
`define IDLE_LEN_W          16
`define MDIO_MEM_ADDR_W     15
`define MDIO_SEL_W          7
`define MDIO_PKT_W          9

// Register addresses
`define ADDR_PHY_ADDR       21'h0
`define ADDR_PHY_MODE       21'h1
`define ADDR_PKT_CTRL       21'h2
`define ADDR_IDLE_LEN       21'h3
`define ADDR_MDIO_ADDR      21'h4
`define ADDR_MDIO_SEL       21'h5
`define ADDR_MDIO_DATA      21'h6
`define ADDR_MDIO_CMD       21'h7

// PHY address group at 0x0
`define LEGAL_ADDR_MSB      14
`define LEGAL_ADDR_LSB      10
`define ADDR_MASK_MSB       9
`define ADDR_MASK_LSB       5
`define BCAST_ADDR_MSB      4
`define BCAST_ADDR_LSB      0

// Mode bits at 0x1
`define MODE_BCAST_BIT      4
`define MODE_NZD_BIT        3
`define MODE_OD_BIT         2
`define MODE_WDOG_BIT       1
`define MODE_SYNC_BIT       0

// Packet control at 0x2
`define PKT_SELF_TEST_BIT   6
`define PKT_LEN_MSB         5
`define PKT_LEN_LSB         4
`define PKT_CAP_MODE_BIT    3
`define PKT_CAP_START_BIT   2
`define PKT_CAP_AGAIN_BIT   1
`define PKT_PATH96_BIT      0
`define MDIO_READ_BIT       0

// Reset values, the rest clear to zero
`define RST_PHY_ADDR        5'h1f
`define RST_BCAST_MODE      1'b1
`define RST_OPENDRAIN       1'b1
`define RST_PATH96          1'b1
`define RST_IDLE_LEN        16'h7fff

`endif

// ==== verilog/regfile_map_pkg.sv ====
// ------------------------------------------------
// Register map types: the register index and the
// field types shared by storage and readback.
// ------------------------------------------------
`default_nettype none

`include "regfile_defs.svh"

package regfile_map_pkg;

    typedef enum logic [3:0] {
        REG_PHY_ADDR  = 4'd0,
        REG_PHY_MODE  = 4'd1,
        REG_PKT_CTRL  = 4'd2,
        REG_IDLE_LEN  = 4'd3,
        REG_MDIO_ADDR = 4'd4,
        REG_MDIO_SEL  = 4'd5,
        REG_MDIO_DATA = 4'd6,
        REG_MDIO_CMD  = 4'd7,
        REG_NONE      = 4'd15
    } reg_index_e;

    typedef logic [`PHY_ADDR_W-1:0]      phy_addr_t;
    typedef logic [`PKT_LEN_SEL_W-1:0]   pkt_len_t;
    typedef logic [`IDLE_LEN_W-1:0]      idle_len_t;
    typedef logic [`MDIO_MEM_ADDR_W-1:0] mdio_addr_t;
    typedef logic [`MDIO_SEL_W-1:0]      mdio_sel_t;
    typedef logic [`MDIO_PKT_W-1:0]      mdio_pkt_t;

endpackage

`default_nettype wire

// ==== verilog/regfile_readback.sv ====
// ------------------------------------------------
// Read data mux. Packs the addressed register into
// the bus word with zero fill; returns zero when
// there is no read access.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "regfile_defs.svh"

module regfile_readback (
    input  apb_bus_pkg::apb_op_e        op,
    input  regfile_map_pkg::reg_index_e index,
    reg_values_if.readback              vals,
    output apb_bus_pkg::bus_data_t      req_prdata
);

    always_comb begin
        req_prdata = '0;
        if (op == apb_bus_pkg::OP_READ) begin
            case (index)
                regfile_map_pkg::REG_PHY_ADDR: begin
                    req_prdata[`LEGAL_ADDR_MSB:`LEGAL_ADDR_LSB] = vals.legal_phy_addr;
                    req_prdata[`ADDR_MASK_MSB:`ADDR_MASK_LSB]   = vals.legal_phy_addr_mask;
                    req_prdata[`BCAST_ADDR_MSB:`BCAST_ADDR_LSB] = vals.broadcast_addr;
                end
                regfile_map_pkg::REG_PHY_MODE: begin
                    req_prdata[`MODE_BCAST_BIT] = vals.broadcast_mode;
                    req_prdata[`MODE_NZD_BIT]   = vals.non_zero_detect;
                    req_prdata[`MODE_OD_BIT]    = vals.opendrain_mode;
                    req_prdata[`MODE_WDOG_BIT]  = vals.watchdog_enable;
                    req_prdata[`MODE_SYNC_BIT]  = vals.sync_select;
                end
                // Capture strobes read back as zero
                regfile_map_pkg::REG_PKT_CTRL: begin
                    req_prdata[`PKT_SELF_TEST_BIT]         = vals.self_test_mode;
                    req_prdata[`PKT_LEN_MSB:`PKT_LEN_LSB] = vals.pkt_data_length;
                    req_prdata[`PKT_CAP_MODE_BIT]          = vals.capture_mode;
                    req_prdata[`PKT_PATH96_BIT]            = vals.path96_en;
                end
                regfile_map_pkg::REG_IDLE_LEN: begin
                    req_prdata = vals.pkt_idle_length;
                end
                regfile_map_pkg::REG_MDIO_ADDR: begin
                    req_prdata[`MDIO_MEM_ADDR_W-1:0] = vals.mdio_memory_addr;
                end
                regfile_map_pkg::REG_MDIO_SEL: begin
                    req_prdata[`MDIO_SEL_W-1:0] = vals.mdio_data_sel;
                end
                regfile_map_pkg::REG_MDIO_DATA: begin
                    req_prdata[`MDIO_PKT_W-1:0] = vals.mdio_pkt_data;
                end
                // 0x7 is write-only, unmapped reads give zero
                default: req_prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/regfile_storage.sv ====
// ------------------------------------------------
// Register storage. Bus writes load the indexed
// register, strobes clear themselves one cycle
// later, and the MDIO packet data is captured
// from the device side only.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "regfile_defs.svh"

module regfile_storage (
    input  logic                        clk,
    input  logic                        reset,
    input  apb_bus_pkg::apb_op_e        op,
    input  regfile_map_pkg::reg_index_e index,
    input  apb_bus_pkg::bus_data_t      wdata,
    input  regfile_map_pkg::mdio_pkt_t  rf_mdio_pkt_data,
    input  logic                        rf_mdio_pkt_data_we,
    reg_values_if.storage               vals
);

    logic bus_we;

    assign bus_we = (op == apb_bus_pkg::OP_WRITE);

    // ----------------------------------------------
    // Read-write fields
    // ----------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            vals.legal_phy_addr      <= `RST_PHY_ADDR;
            vals.legal_phy_addr_mask <= `RST_PHY_ADDR;
            vals.broadcast_addr      <= `RST_PHY_ADDR;
            vals.broadcast_mode      <= `RST_BCAST_MODE;
            vals.non_zero_detect     <= 1'b0;
            vals.opendrain_mode      <= `RST_OPENDRAIN;
            vals.watchdog_enable     <= 1'b0;
            vals.sync_select         <= 1'b0;
            vals.self_test_mode      <= 1'b0;
            vals.pkt_data_length     <= '0;
            vals.capture_mode        <= 1'b0;
            vals.path96_en           <= `RST_PATH96;
            vals.pkt_idle_length     <= `RST_IDLE_LEN;
            vals.mdio_memory_addr    <= '0;
            vals.mdio_data_sel       <= '0;
        end else if (bus_we) begin
            case (index)
                regfile_map_pkg::REG_PHY_ADDR: begin
                    vals.legal_phy_addr      <= wdata[`LEGAL_ADDR_MSB:`LEGAL_ADDR_LSB];
                    vals.legal_phy_addr_mask <= wdata[`ADDR_MASK_MSB:`ADDR_MASK_LSB];
                    vals.broadcast_addr      <= wdata[`BCAST_ADDR_MSB:`BCAST_ADDR_LSB];
                end
                regfile_map_pkg::REG_PHY_MODE: begin
                    vals.broadcast_mode  <= wdata[`MODE_BCAST_BIT];
                    vals.non_zero_detect <= wdata[`MODE_NZD_BIT];
                    vals.opendrain_mode  <= wdata[`MODE_OD_BIT];
                    vals.watchdog_enable <= wdata[`MODE_WDOG_BIT];
                    vals.sync_select     <= wdata[`MODE_SYNC_BIT];
                end
                regfile_map_pkg::REG_PKT_CTRL: begin
                    vals.self_test_mode  <= wdata[`PKT_SELF_TEST_BIT];
                    vals.pkt_data_length <= wdata[`PKT_LEN_MSB:`PKT_LEN_LSB];
                    vals.capture_mode    <= wdata[`PKT_CAP_MODE_BIT];
                    vals.path96_en       <= wdata[`PKT_PATH96_BIT];
                end
                regfile_map_pkg::REG_IDLE_LEN:  vals.pkt_idle_length <= wdata;
                regfile_map_pkg::REG_MDIO_ADDR: begin
                    vals.mdio_memory_addr <= wdata[`MDIO_MEM_ADDR_W-1:0];
                end
                regfile_map_pkg::REG_MDIO_SEL:  vals.mdio_data_sel <= wdata[`MDIO_SEL_W-1:0];
                default: ;
            endcase
        end
    end

    // ----------------------------------------------
    // Self-clearing strobes, high for one cycle
    // ----------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            vals.capture_start   <= 1'b0;
            vals.capture_again   <= 1'b0;
            vals.mdio_read_pulse <= 1'b0;
        end else begin
            vals.capture_start   <= bus_we && (index == regfile_map_pkg::REG_PKT_CTRL)
                                    && wdata[`PKT_CAP_START_BIT];
            vals.capture_again   <= bus_we && (index == regfile_map_pkg::REG_PKT_CTRL)
                                    && wdata[`PKT_CAP_AGAIN_BIT];
            vals.mdio_read_pulse <= bus_we && (index == regfile_map_pkg::REG_MDIO_CMD)
                                    && wdata[`MDIO_READ_BIT];
        end
    end

    // Device capture, bus writes to 0x6 are ignored
    always_ff @(posedge clk) begin
        if (reset) begin
            vals.mdio_pkt_data <= '0;
        end else if (rf_mdio_pkt_data_we) begin
            vals.mdio_pkt_data <= rf_mdio_pkt_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/top_regfile.sv ====
// ------------------------------------------------
// Config register file top. APB slave port on one
// side, register fields as plain outputs on the
// other. Zero wait states.
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module top_regfile (
    input  logic                        clk,
    input  logic                        reset,
    input  apb_bus_pkg::bus_addr_t      req_paddr,
    input  logic                        req_pwrite,
    input  logic                        req_psel,
    input  logic                        req_penable,
    input  apb_bus_pkg::bus_data_t      req_pwdata,
    output apb_bus_pkg::bus_data_t      req_prdata,
    output regfile_map_pkg::phy_addr_t  legal_phy_addr,
    output regfile_map_pkg::phy_addr_t  legal_phy_addr_mask,
    output regfile_map_pkg::phy_addr_t  broadcast_addr,
    output logic                        broadcast_mode,
    output logic                        non_zero_detect,
    output logic                        opendrain_mode,
    output logic                        watchdog_enable,
    output logic                        sync_select,
    output logic                        rf_self_test_mode,
    output logic                        rf_capture_mode,
    output logic                        rf_capture_start,
    output logic                        rf_capture_again,
    output logic                        rf_96path_en,
    output regfile_map_pkg::pkt_len_t   rf_pkt_data_length,
    output regfile_map_pkg::idle_len_t  rf_pkt_idle_length,
    output logic                        rf_mdio_read_pulse,
    output regfile_map_pkg::mdio_sel_t  rf_mdio_data_sel,
    output regfile_map_pkg::mdio_addr_t rf_mdio_memory_addr,
    input  regfile_map_pkg::mdio_pkt_t  rf_mdio_pkt_data,
    input  logic                        rf_mdio_pkt_data_we
);

    apb_bus_pkg::apb_op_e        op;
    regfile_map_pkg::reg_index_e index;

    reg_values_if vals ();

    regfile_decode u_decode (
        .req_paddr   (req_paddr),
        .req_psel    (req_psel),
        .req_penable (req_penable),
        .req_pwrite  (req_pwrite),
        .op          (op),
        .index       (index)
    );

    regfile_storage u_storage (
        .clk                 (clk),
        .reset               (reset),
        .op                  (op),
        .index               (index),
        .wdata               (req_pwdata),
        .rf_mdio_pkt_data    (rf_mdio_pkt_data),
        .rf_mdio_pkt_data_we (rf_mdio_pkt_data_we),
        .vals                (vals.storage)
    );

    regfile_readback u_readback (
        .op         (op),
        .index      (index),
        .vals       (vals.readback),
        .req_prdata (req_prdata)
    );

    // Device side outputs
    assign legal_phy_addr      = vals.legal_phy_addr;
    assign legal_phy_addr_mask = vals.legal_phy_addr_mask;
    assign broadcast_addr      = vals.broadcast_addr;
    assign broadcast_mode      = vals.broadcast_mode;
    assign non_zero_detect     = vals.non_zero_detect;
    assign opendrain_mode      = vals.opendrain_mode;
    assign watchdog_enable     = vals.watchdog_enable;
    assign sync_select         = vals.sync_select;
    assign rf_self_test_mode   = vals.self_test_mode;
    assign rf_capture_mode     = vals.capture_mode;
    assign rf_capture_start    = vals.capture_start;
    assign rf_capture_again    = vals.capture_again;
    assign rf_96path_en        = vals.path96_en;
    assign rf_pkt_data_length  = vals.pkt_data_length;
    assign rf_pkt_idle_length  = vals.pkt_idle_length;
    assign rf_mdio_read_pulse  = vals.mdio_read_pulse;
    assign rf_mdio_data_sel    = vals.mdio_data_sel;
    assign rf_mdio_memory_addr = vals.mdio_memory_addr;

endmodule

`default_nettype wire
